/* project.f */
common/eth_ll_pkg.sv
common/eth_client_pkg.sv
fifo/eth_frame_ram.sv
fifo/eth_rx_client_fifo.sv
fifo/eth_tx_client_fifo.sv
logic/eth_client_reset_sync.sv
logic/eth_client_locallink.sv
sim/eth_client_locallink_asserts.sv
sim/tb_eth_client_locallink.sv

/* Makefile */
# Verilator simulation of the client local-link wrapper

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_eth_client_locallink -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_eth_client_locallink.sv */
`timescale 1ns/1ps

module tb_eth_client_locallink;

    // One row of the stimulus table
    typedef struct {
        bit         tx;
        int         len;
        logic [7:0] first;
        bit         good;
        bit         ovf;
        bit         hold;
    } frame_case_t;

    logic                              rx_clk_0_i;
    logic                              reset_i;
    logic                              resetdone_i;
    logic [eth_client_pkg::DATA_W-1:0] rx_data_i;
    logic                              rx_data_valid_i;
    logic                              rx_good_frame_i;
    logic                              rx_bad_frame_i;
    logic [eth_client_pkg::DATA_W-1:0] tx_data_o;
    logic                              tx_data_valid_o;
    logic                              tx_ack_i;
    logic [eth_client_pkg::DATA_W-1:0] rx_ll_data_o;
    logic                              rx_ll_sof_n_o;
    logic                              rx_ll_eof_n_o;
    logic                              rx_ll_src_rdy_n_o;
    logic                              rx_ll_dst_rdy_n_i;
    logic [eth_ll_pkg::STATUS_W-1:0]   rx_ll_fifo_status_o;
    logic                              rx_overflow_o;
    logic [eth_client_pkg::DATA_W-1:0] tx_ll_data_i;
    logic                              tx_ll_sof_n_i;
    logic                              tx_ll_eof_n_i;
    logic                              tx_ll_src_rdy_n_i;
    logic                              tx_ll_dst_rdy_n_o;

    frame_case_t cases[$];
    logic [9:0]  rx_exp[$];
    logic [7:0]  tx_exp[$];
    int          tx_len_exp[$];
    logic [7:0]  lfsr;
    logic [9:0]  exp_word;
    logic [7:0]  tx_first;
    int          errors;
    int          failed_cases;
    int          ovf_count;
    int          tx_done;
    int          tx_phase;
    int          tx_cnt;
    int          tx_delay;
    bit          hold_bp;
    bit          timed_out;

    eth_client_locallink dut0 (.*);

    initial
    begin
        rx_clk_0_i = 1'b0;
        forever #50 rx_clk_0_i = ~rx_clk_0_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic step_lfsr();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expv, input logic [31:0] gotv);
        assert (gotv === expv)
        else
        begin
            $display("FAIL %s expected %h got %h", name, expv, gotv);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic add_case(input bit tx, input int len, input logic [7:0] first,
                            input bit good, input bit ovf, input bit hold);
        frame_case_t c;
        c.tx    = tx;
        c.len   = len;
        c.first = first;
        c.good  = good;
        c.ovf   = ovf;
        c.hold  = hold;
        cases.push_back(c);
    endtask

    // ----------------------------------------
    // Local-link sink and MAC transmit model
    // ----------------------------------------

    always @(negedge rx_clk_0_i)
    begin
        // Ready for the coming edge, outputs are flops and stay put
        rx_ll_dst_rdy_n_i = hold_bp ? 1'b1 : step_lfsr();
        if (!rx_ll_src_rdy_n_o && !rx_ll_dst_rdy_n_i)
        begin
            if (rx_exp.size() == 0)
            begin
                $display("Unexpected byte %h on the receive local link", rx_ll_data_o);
                errors++;
            end
            else
            begin
                exp_word = rx_exp.pop_front();
                check_eq("rx_ll_data_o", exp_word[7:0], rx_ll_data_o);
                check_eq("rx_ll_sof_n_o", !exp_word[9], rx_ll_sof_n_o);
                check_eq("rx_ll_eof_n_o", !exp_word[8], rx_ll_eof_n_o);
            end
        end
        if (rx_overflow_o)
            ovf_count++;
        // Waiting for ack, first byte must sit still
        if (tx_phase == 1)
        begin
            if (tx_ack_i)
            begin
                // Ack was taken at the last edge, second byte is out now
                tx_ack_i = 1'b0;
                tx_phase = 2;
            end
            else
            begin
                check_eq("tx_data_valid_o", 1, tx_data_valid_o);
                check_eq("tx_data_o", tx_first, tx_data_o);
                tx_delay--;
                if (tx_delay <= 0)
                    tx_ack_i = 1'b1;
            end
        end
        // Streaming, one byte per clock until valid drops
        if (tx_phase == 2)
        begin
            if (tx_data_valid_o)
            begin
                if (tx_exp.size() == 0)
                begin
                    $display("Unexpected byte %h on the MAC transmit side", tx_data_o);
                    errors++;
                end
                else
                    check_eq("tx_data_o", tx_exp.pop_front(), tx_data_o);
                tx_cnt++;
            end
            else
            begin
                if (tx_len_exp.size() == 0)
                begin
                    $display("Transmit frame seen with none expected");
                    errors++;
                end
                else
                    check_eq("tx frame length", tx_len_exp.pop_front(), tx_cnt);
                tx_done++;
                tx_phase = 0;
            end
        end
        if (tx_phase == 0 && tx_data_valid_o)
        begin
            if (tx_exp.size() == 0)
            begin
                $display("Unexpected frame start on the MAC transmit side");
                errors++;
                tx_first = tx_data_o;
            end
            else
            begin
                tx_first = tx_exp.pop_front();
                check_eq("tx_data_o", tx_first, tx_data_o);
            end
            tx_cnt   = 1;
            tx_delay = {step_lfsr(), step_lfsr()};
            tx_phase = 1;
            tx_ack_i = (tx_delay == 0);
        end
    end

    // ----------------------------------------
    // Frame drivers
    // ----------------------------------------

    task automatic run_rx_case(input frame_case_t c);
        int ovf_before;
        int n;
        ovf_before = ovf_count;
        hold_bp = c.hold;
        if (c.good && !c.ovf)
        begin
            for (int i = 0; i < c.len; i++)
                rx_exp.push_back({i == 0, i == c.len - 1, 8'(c.first + i)});
        end
        for (int i = 0; i < c.len; i++)
        begin
            @(negedge rx_clk_0_i);
            rx_data_i       = 8'(c.first + i);
            rx_data_valid_i = 1'b1;
        end
        @(negedge rx_clk_0_i);
        rx_data_valid_i = 1'b0;
        rx_good_frame_i = c.good;
        rx_bad_frame_i  = !c.good;
        @(negedge rx_clk_0_i);
        rx_good_frame_i = 1'b0;
        rx_bad_frame_i  = 1'b0;
        n = 0;
        while (c.ovf && ovf_count == ovf_before && !timed_out)
        begin
            @(negedge rx_clk_0_i);
            n++;
            if (n > 20)
                note_timeout("the receive overflow pulse");
        end
        // Held back-pressure lets the status settle on one frame
        n = 0;
        while (c.hold && !c.ovf && rx_ll_src_rdy_n_o && !timed_out)
        begin
            @(negedge rx_clk_0_i);
            n++;
            if (n > 20)
                note_timeout("the receive frame to arrive");
        end
        if (c.hold && !c.ovf)
        begin
            repeat (2) @(negedge rx_clk_0_i);
            check_eq("rx_ll_fifo_status_o", (c.len / 16 > 15) ? 15 : c.len / 16,
                     rx_ll_fifo_status_o);
        end
        hold_bp = 1'b0;
        n = 0;
        while (rx_exp.size() != 0 && !timed_out)
        begin
            @(negedge rx_clk_0_i);
            n++;
            if (n > 3000)
                note_timeout("the receive local link to drain");
        end
        repeat (4) @(negedge rx_clk_0_i);
        check_eq("rx_overflow_o pulses", ovf_before + c.ovf, ovf_count);
    endtask

    task automatic run_tx_case(input frame_case_t c);
        int done_before;
        int n;
        done_before = tx_done;
        tx_len_exp.push_back(c.len);
        for (int i = 0; i < c.len; i++)
            tx_exp.push_back(8'(c.first + i));
        for (int i = 0; i < c.len && !timed_out; i++)
        begin
            @(negedge rx_clk_0_i);
            tx_ll_src_rdy_n_i = 1'b0;
            tx_ll_data_i      = 8'(c.first + i);
            tx_ll_sof_n_i     = (i != 0);
            tx_ll_eof_n_i     = (i != c.len - 1);
            n = 0;
            while (tx_ll_dst_rdy_n_o && !timed_out)
            begin
                @(negedge rx_clk_0_i);
                n++;
                if (n > 100)
                    note_timeout("transmit local-link ready");
            end
        end
        @(negedge rx_clk_0_i);
        tx_ll_src_rdy_n_i = 1'b1;
        tx_ll_sof_n_i     = 1'b1;
        tx_ll_eof_n_i     = 1'b1;
        n = 0;
        while (tx_done == done_before && !timed_out)
        begin
            @(negedge rx_clk_0_i);
            n++;
            if (n > 1000)
                note_timeout("the transmit frame on the MAC side");
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial
    begin
        int cycles;
        int err_before;
        lfsr = 8'd44;
        errors = 0;
        failed_cases = 0;
        ovf_count = 0;
        tx_done = 0;
        tx_phase = 0;
        tx_cnt = 0;
        tx_delay = 0;
        hold_bp = 1'b0;
        timed_out = 1'b0;
        reset_i = 1'b1;
        resetdone_i = 1'b0;
        rx_data_i = '0;
        rx_data_valid_i = 1'b0;
        rx_good_frame_i = 1'b0;
        rx_bad_frame_i = 1'b0;
        rx_ll_dst_rdy_n_i = 1'b1;
        tx_ack_i = 1'b0;
        tx_ll_data_i = '0;
        tx_ll_sof_n_i = 1'b1;
        tx_ll_eof_n_i = 1'b1;
        tx_ll_src_rdy_n_i = 1'b1;

        // dir, length, first byte, good, overflow, hold back-pressure
        add_case(0, 1, 8'h10, 1, 0, 0);
        add_case(0, 5, 8'h20, 1, 0, 0);
        add_case(0, 64, 8'h40, 1, 0, 0);
        add_case(0, 8, 8'h80, 0, 0, 0);
        add_case(0, 12, 8'h90, 1, 0, 0);
        add_case(0, 300, 8'h00, 1, 1, 1);
        add_case(0, 6, 8'hA0, 1, 0, 0);
        add_case(0, 48, 8'hB0, 1, 0, 1);
        add_case(0, 256, 8'h05, 1, 0, 1);
        add_case(1, 1, 8'hC0, 1, 0, 0);
        add_case(1, 7, 8'hD0, 1, 0, 0);
        add_case(1, 60, 8'h10, 1, 0, 0);
        add_case(1, 3, 8'h70, 1, 0, 0);

        repeat (2) @(negedge rx_clk_0_i);
        reset_i = 1'b0;
        repeat (3) @(negedge rx_clk_0_i);
        resetdone_i = 1'b1;
        cycles = 0;
        while (!timed_out)
        begin
            @(negedge rx_clk_0_i);
            cycles++;
            if (!tx_ll_dst_rdy_n_o)
                break;
            check_eq("rx_ll_src_rdy_n_o", 1, rx_ll_src_rdy_n_o);
            check_eq("tx_data_valid_o", 0, tx_data_valid_o);
            if (cycles > 50)
                note_timeout("the FIFOs to leave reset");
        end
        assert (cycles >= eth_client_pkg::RESET_DELAY + 1)
        else
        begin
            $display("FAIL tx_ll_dst_rdy_n_o fell after %h cycles, expected at least %h",
                     cycles, eth_client_pkg::RESET_DELAY + 1);
            errors++;
        end
        $display("case reset: %s", (errors == 0) ? "ok" : "errors");

        foreach (cases[k])
        begin
            err_before = errors;
            if (cases[k].tx)
                run_tx_case(cases[k]);
            else
                run_rx_case(cases[k]);
            if (errors != err_before)
                failed_cases++;
            $display("case %0d %s len %0d: %s", k, cases[k].tx ? "tx" : "rx", cases[k].len,
                     (errors == err_before) ? "ok" : "errors");
            if (timed_out)
                break;
        end

        $display("%0d cases run, %0d failed, %0d errors", cases.size(), failed_cases, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* sim/eth_client_locallink_asserts.sv */
`timescale 1ns/1ps

module eth_client_locallink_asserts
(
    input logic       rx_clk_0_i,
    input logic       reset_i,
    input logic       fifo_reset_i,
    input logic [7:0] ll_data_i,
    input logic       ll_sof_n_i,
    input logic       ll_eof_n_i,
    input logic       ll_src_rdy_n_i,
    input logic       ll_dst_rdy_n_i,
    input logic [3:0] ll_status_i,
    input logic       overflow_i,
    input logic       tx_valid_i,
    input logic       tx_ack_i,
    input logic       tx_dst_rdy_n_i
);

    // Set once the MAC has taken the first byte of a frame
    logic acked;

    always_ff @(posedge rx_clk_0_i or posedge reset_i)
    begin
        if (reset_i)
            acked <= 1'b0;
        else if (!tx_valid_i)
            acked <= 1'b0;
        else if (tx_ack_i)
            acked <= 1'b1;
    end

    // Stalled receive byte holds
    rx_stall_stable: assert property (@(posedge rx_clk_0_i) disable iff (reset_i)
        !fifo_reset_i && !ll_src_rdy_n_i && ll_dst_rdy_n_i |=>
        $stable(ll_data_i) && $stable(ll_sof_n_i) && $stable(ll_eof_n_i) && !ll_src_rdy_n_i)
        else $error("receive local link changed while stalled");

    // First byte stays up until ack
    tx_hold_to_ack: assert property (@(posedge rx_clk_0_i) disable iff (reset_i)
        tx_valid_i && !tx_ack_i && !acked |=> tx_valid_i)
        else $error("tx_data_valid_o fell before ack");

    // FIFOs quiet while held in reset
    quiet_in_reset: assert property (@(posedge rx_clk_0_i) disable iff (reset_i)
        fifo_reset_i |-> ll_src_rdy_n_i && ll_sof_n_i && ll_eof_n_i && ll_status_i == 0
                         && tx_dst_rdy_n_i && !tx_valid_i && !overflow_i)
        else $error("control output active during FIFO reset");

endmodule

bind eth_client_locallink eth_client_locallink_asserts asserts0
(
    .rx_clk_0_i     (rx_clk_0_i),
    .reset_i        (reset_i),
    .fifo_reset_i   (fifo_reset),
    .ll_data_i      (rx_ll_data_o),
    .ll_sof_n_i     (rx_ll_sof_n_o),
    .ll_eof_n_i     (rx_ll_eof_n_o),
    .ll_src_rdy_n_i (rx_ll_src_rdy_n_o),
    .ll_dst_rdy_n_i (rx_ll_dst_rdy_n_i),
    .ll_status_i    (rx_ll_fifo_status_o),
    .overflow_i     (rx_overflow_o),
    .tx_valid_i     (tx_data_valid_o),
    .tx_ack_i       (tx_ack_i),
    .tx_dst_rdy_n_i (tx_ll_dst_rdy_n_o)
);

/* logic/eth_client_locallink.sv */
`timescale 1ns/1ps

module eth_client_locallink
(
    input  logic                              rx_clk_0_i,
    input  logic                              reset_i,
    input  logic                              resetdone_i,
    // MAC receive client
    input  logic [eth_client_pkg::DATA_W-1:0] rx_data_i,
    input  logic                              rx_data_valid_i,
    input  logic                              rx_good_frame_i,
    input  logic                              rx_bad_frame_i,
    // MAC transmit client
    output logic [eth_client_pkg::DATA_W-1:0] tx_data_o,
    output logic                              tx_data_valid_o,
    input  logic                              tx_ack_i,
    // Receive local link
    output logic [eth_client_pkg::DATA_W-1:0] rx_ll_data_o,
    output logic                              rx_ll_sof_n_o,
    output logic                              rx_ll_eof_n_o,
    output logic                              rx_ll_src_rdy_n_o,
    input  logic                              rx_ll_dst_rdy_n_i,
    output logic [eth_ll_pkg::STATUS_W-1:0]   rx_ll_fifo_status_o,
    output logic                              rx_overflow_o,
    // Transmit local link
    input  logic [eth_client_pkg::DATA_W-1:0] tx_ll_data_i,
    input  logic                              tx_ll_sof_n_i,
    input  logic                              tx_ll_eof_n_i,
    input  logic                              tx_ll_src_rdy_n_i,
    output logic                              tx_ll_dst_rdy_n_o
);

    logic                              fifo_reset;
    logic [eth_client_pkg::DATA_W-1:0] rx_data_r;
    logic                              rx_data_valid_r;
    logic                              rx_good_frame_r;
    logic                              rx_bad_frame_r;

    // ----------------------------------------
    // FIFO reset
    // ----------------------------------------

    // Both FIFOs stay in reset until the transceiver settles
    eth_client_reset_sync reset_sync0
    (
        .rx_clk_0_i   (rx_clk_0_i),
        .reset_i      (reset_i),
        .resetdone_i  (resetdone_i),
        .fifo_reset_o (fifo_reset)
    );

    // ----------------------------------------
    // Receive path
    // ----------------------------------------

    // One register stage on the MAC outputs
    always_ff @(posedge rx_clk_0_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            rx_data_r       <= '0;
            rx_data_valid_r <= 1'b0;
            rx_good_frame_r <= 1'b0;
            rx_bad_frame_r  <= 1'b0;
        end
        else if (resetdone_i)
        begin
            rx_data_r       <= rx_data_i;
            rx_data_valid_r <= rx_data_valid_i;
            rx_good_frame_r <= rx_good_frame_i;
            rx_bad_frame_r  <= rx_bad_frame_i;
        end
    end

    eth_rx_client_fifo rx_fifo0
    (
        .rx_clk_0_i          (rx_clk_0_i),
        .fifo_reset_i        (fifo_reset),
        .rx_data_i           (rx_data_r),
        .rx_data_valid_i     (rx_data_valid_r),
        .rx_good_frame_i     (rx_good_frame_r),
        .rx_bad_frame_i      (rx_bad_frame_r),
        .rx_ll_dst_rdy_n_i   (rx_ll_dst_rdy_n_i),
        .rx_ll_data_o        (rx_ll_data_o),
        .rx_ll_sof_n_o       (rx_ll_sof_n_o),
        .rx_ll_eof_n_o       (rx_ll_eof_n_o),
        .rx_ll_src_rdy_n_o   (rx_ll_src_rdy_n_o),
        .rx_ll_fifo_status_o (rx_ll_fifo_status_o),
        .rx_overflow_o       (rx_overflow_o)
    );

    // ----------------------------------------
    // Transmit path
    // ----------------------------------------

    // Transmit shares the receive clock
    eth_tx_client_fifo tx_fifo0
    (
        .rx_clk_0_i        (rx_clk_0_i),
        .fifo_reset_i      (fifo_reset),
        .tx_ll_data_i      (tx_ll_data_i),
        .tx_ll_sof_n_i     (tx_ll_sof_n_i),
        .tx_ll_eof_n_i     (tx_ll_eof_n_i),
        .tx_ll_src_rdy_n_i (tx_ll_src_rdy_n_i),
        .tx_ack_i          (tx_ack_i),
        .tx_ll_dst_rdy_n_o (tx_ll_dst_rdy_n_o),
        .tx_data_o         (tx_data_o),
        .tx_data_valid_o   (tx_data_valid_o)
    );

endmodule

/* logic/eth_client_reset_sync.sv */
`timescale 1ns/1ps

module eth_client_reset_sync
(
    input  logic rx_clk_0_i,
    input  logic reset_i,
    input  logic resetdone_i,
    output logic fifo_reset_o
);

    // Shift chain, all ones after reset
    logic [eth_client_pkg::RESET_DELAY-1:0] pre_reset;

    // Zeros enter only while the transceiver reports done
    // The output follows the last stage one edge later
    always_ff @(posedge rx_clk_0_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pre_reset    <= '1;
            fifo_reset_o <= 1'b1;
        end
        else if (resetdone_i)
        begin
            pre_reset    <= {pre_reset[eth_client_pkg::RESET_DELAY-2:0], 1'b0};
            fifo_reset_o <= pre_reset[eth_client_pkg::RESET_DELAY-1];
        end
    end

endmodule

/* fifo/eth_tx_client_fifo.sv */
`timescale 1ns/1ps

module eth_tx_client_fifo
(
    input  logic                              rx_clk_0_i,
    input  logic                              fifo_reset_i,
    input  logic [eth_client_pkg::DATA_W-1:0] tx_ll_data_i,
    input  logic                              tx_ll_sof_n_i,
    input  logic                              tx_ll_eof_n_i,
    input  logic                              tx_ll_src_rdy_n_i,
    input  logic                              tx_ack_i,
    output logic                              tx_ll_dst_rdy_n_o,
    output logic [eth_client_pkg::DATA_W-1:0] tx_data_o,
    output logic                              tx_data_valid_o
);

    // Client side FSM
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_STREAM
    } tx_state_t;

    tx_state_t                         state;
    logic [eth_ll_pkg::FIFO_AW:0]      wr_ptr;
    logic [eth_ll_pkg::FIFO_AW:0]      rd_ptr;
    logic [eth_ll_pkg::FIFO_AW:0]      rd_ptr_nxt;
    logic [eth_ll_pkg::FIFO_AW:0]      used_nxt;
    // Complete frames waiting, up to one per entry
    logic [eth_ll_pkg::FIFO_AW:0]      frames;
    logic                              in_frame;
    logic                              rdy_q;
    logic                              wr_fire;
    logic                              wr_eof;
    logic                              advance;
    logic                              frame_done;
    logic [eth_client_pkg::DATA_W-1:0] ram_rd_data;
    logic                              ram_rd_last;

    // ----------------------------------------
    // Local-link write side
    // ----------------------------------------

    // Bytes outside a sof..eof bracket are not stored
    assign wr_fire = ~tx_ll_src_rdy_n_i & rdy_q & (~tx_ll_sof_n_i | in_frame);
    assign wr_eof = wr_fire & ~tx_ll_eof_n_i;

    // ----------------------------------------
    // Client read side
    // ----------------------------------------

    // First byte moves on at ack, the rest one per clock
    assign advance = (state == ST_STREAM) | ((state == ST_WAIT_ACK) & tx_ack_i);
    assign frame_done = advance & ram_rd_last;
    // RAM reads ahead so its output is the byte at rd_ptr
    assign rd_ptr_nxt = rd_ptr + advance;
    assign used_nxt = (wr_ptr + wr_fire) - rd_ptr_nxt;

    always_ff @(posedge rx_clk_0_i or posedge fifo_reset_i)
    begin
        if (fifo_reset_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            frames   <= '0;
            in_frame <= 1'b0;
            rdy_q    <= 1'b0;
            state    <= ST_IDLE;
        end
        else
        begin
            rd_ptr <= rd_ptr_nxt;
            // Ready drops with the last free entry
            rdy_q <= ~used_nxt[eth_ll_pkg::FIFO_AW];
            if (wr_fire)
            begin
                wr_ptr   <= wr_ptr + 1'b1;
                in_frame <= tx_ll_eof_n_i;
            end
            if (wr_eof & ~frame_done)
            begin
                frames <= frames + 1'b1;
            end
            else if (frame_done & ~wr_eof)
            begin
                frames <= frames - 1'b1;
            end
            case (state)
                ST_IDLE:
                begin
                    // Only whole frames leave, so no underrun
                    if (frames != '0)
                    begin
                        state <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK:
                begin
                    if (tx_ack_i)
                    begin
                        state <= ram_rd_last ? ST_IDLE : ST_STREAM;
                    end
                end
                ST_STREAM:
                begin
                    if (ram_rd_last)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    eth_frame_ram tx_ram0
    (
        .rx_clk_0_i (rx_clk_0_i),
        .wr_en_i    (wr_fire),
        .wr_addr_i  (wr_ptr[eth_ll_pkg::FIFO_AW-1:0]),
        .wr_data_i  (tx_ll_data_i),
        .wr_last_i  (~tx_ll_eof_n_i),
        .rd_addr_i  (rd_ptr_nxt[eth_ll_pkg::FIFO_AW-1:0]),
        .rd_data_o  (ram_rd_data),
        .rd_last_o  (ram_rd_last)
    );

    assign tx_ll_dst_rdy_n_o = ~rdy_q;
    assign tx_data_o         = ram_rd_data;
    assign tx_data_valid_o   = (state != ST_IDLE);

endmodule

/* fifo/eth_rx_client_fifo.sv */
`timescale 1ns/1ps

module eth_rx_client_fifo
(
    input  logic                              rx_clk_0_i,
    input  logic                              fifo_reset_i,
    input  logic [eth_client_pkg::DATA_W-1:0] rx_data_i,
    input  logic                              rx_data_valid_i,
    input  logic                              rx_good_frame_i,
    input  logic                              rx_bad_frame_i,
    input  logic                              rx_ll_dst_rdy_n_i,
    output logic [eth_client_pkg::DATA_W-1:0] rx_ll_data_o,
    output logic                              rx_ll_sof_n_o,
    output logic                              rx_ll_eof_n_o,
    output logic                              rx_ll_src_rdy_n_o,
    output logic [eth_ll_pkg::STATUS_W-1:0]   rx_ll_fifo_status_o,
    output logic                              rx_overflow_o
);

    // Pointers carry an extra wrap bit, full versus empty
    logic [eth_ll_pkg::FIFO_AW:0]      wr_ptr;
    logic [eth_ll_pkg::FIFO_AW:0]      cmt_ptr;
    logic [eth_ll_pkg::FIFO_AW:0]      rd_ptr;
    logic [eth_ll_pkg::FIFO_AW:0]      rd_ptr_nxt;
    logic [eth_ll_pkg::FIFO_AW:0]      used;
    logic [eth_ll_pkg::FIFO_AW:0]      occ;
    logic                              marker;
    logic                              drop_q;
    logic                              drop_now;
    logic                              wr_fire;
    logic                              commit;
    logic [eth_client_pkg::DATA_W-1:0] last_data;
    logic                              ram_wr_en;
    logic [eth_ll_pkg::FIFO_AW-1:0]    ram_wr_addr;
    logic [eth_client_pkg::DATA_W-1:0] ram_wr_data;
    logic [eth_client_pkg::DATA_W-1:0] ram_rd_data;
    logic                              ram_rd_last;
    logic                              ram_vld;
    logic                              pop;
    logic                              sof_pend;
    logic                              out_vld;
    logic                              out_sof;
    logic                              out_last;
    logic [eth_client_pkg::DATA_W-1:0] out_data;

    // ----------------------------------------
    // Write side, speculative until the marker
    // ----------------------------------------

    assign marker = rx_good_frame_i | rx_bad_frame_i;
    // Space is measured against the read pointer, uncommitted bytes included
    assign used = wr_ptr - rd_ptr;
    // Once a byte finds no room the rest of the frame is thrown away
    assign drop_now = drop_q | (rx_data_valid_i & used[eth_ll_pkg::FIFO_AW]);
    assign wr_fire = rx_data_valid_i & ~drop_now;
    assign commit = rx_good_frame_i & ~drop_now;

    // Marker with a byte: that byte is the last one
    // Marker alone: rewrite the previous byte with its end flag set
    assign ram_wr_en = wr_fire | commit;
    assign ram_wr_addr = wr_fire ? wr_ptr[eth_ll_pkg::FIFO_AW-1:0]
                                 : wr_ptr[eth_ll_pkg::FIFO_AW-1:0] - 1'b1;
    assign ram_wr_data = wr_fire ? rx_data_i : last_data;

    always_ff @(posedge rx_clk_0_i or posedge fifo_reset_i)
    begin
        if (fifo_reset_i)
        begin
            wr_ptr        <= '0;
            cmt_ptr       <= '0;
            drop_q        <= 1'b0;
            rx_overflow_o <= 1'b0;
        end
        else
        begin
            // One pulse per dropped frame, good or bad
            rx_overflow_o <= marker & drop_now;
            if (commit)
            begin
                wr_ptr  <= wr_ptr + wr_fire;
                cmt_ptr <= wr_ptr + wr_fire;
            end
            else if (marker)
            begin
                // Bad or overflowed frame, rewind
                wr_ptr <= cmt_ptr;
            end
            else if (wr_fire)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            drop_q <= drop_now & ~marker;
        end
    end

    // Copy of the newest byte for the end-flag rewrite
    always_ff @(posedge rx_clk_0_i)
    begin
        if (wr_fire)
        begin
            last_data <= rx_data_i;
        end
    end

    eth_frame_ram rx_ram0
    (
        .rx_clk_0_i (rx_clk_0_i),
        .wr_en_i    (ram_wr_en),
        .wr_addr_i  (ram_wr_addr),
        .wr_data_i  (ram_wr_data),
        .wr_last_i  (rx_good_frame_i),
        .rd_addr_i  (rd_ptr_nxt[eth_ll_pkg::FIFO_AW-1:0]),
        .rd_data_o  (ram_rd_data),
        .rd_last_o  (ram_rd_last)
    );

    // ----------------------------------------
    // Read side, committed bytes only
    // ----------------------------------------

    // RAM output holds the entry at rd_ptr whenever ram_vld is set
    assign pop = ram_vld & (~out_vld | ~rx_ll_dst_rdy_n_i);
    assign rd_ptr_nxt = rd_ptr + pop;
    // Committed bytes not yet taken, the output register included
    assign occ = cmt_ptr - rd_ptr + out_vld;

    always_ff @(posedge rx_clk_0_i or posedge fifo_reset_i)
    begin
        if (fifo_reset_i)
        begin
            rd_ptr              <= '0;
            ram_vld             <= 1'b0;
            out_vld             <= 1'b0;
            sof_pend            <= 1'b1;
            rx_ll_fifo_status_o <= '0;
        end
        else
        begin
            rd_ptr <= rd_ptr_nxt;
            // Pre-edge commit pointer, so a fresh commit waits one read
            ram_vld <= (rd_ptr_nxt != cmt_ptr);
            if (pop)
            begin
                out_vld  <= 1'b1;
                // Next byte opens a frame after an end flag
                sof_pend <= ram_rd_last;
            end
            else if (~rx_ll_dst_rdy_n_i)
            begin
                out_vld <= 1'b0;
            end
            // Occupancy over 16, saturated
            if (occ[eth_ll_pkg::FIFO_AW:4] >= (1 << eth_ll_pkg::STATUS_W))
            begin
                rx_ll_fifo_status_o <= '1;
            end
            else
            begin
                rx_ll_fifo_status_o <= occ[eth_ll_pkg::STATUS_W+3:4];
            end
        end
    end

    // Output byte and markers, held while stalled
    always_ff @(posedge rx_clk_0_i)
    begin
        if (pop)
        begin
            out_data <= ram_rd_data;
            out_last <= ram_rd_last;
            out_sof  <= sof_pend;
        end
    end

    assign rx_ll_data_o      = out_data;
    assign rx_ll_src_rdy_n_o = ~out_vld;
    assign rx_ll_sof_n_o     = ~(out_vld & out_sof);
    assign rx_ll_eof_n_o     = ~(out_vld & out_last);

endmodule

/* fifo/eth_frame_ram.sv */
`timescale 1ns/1ps

module eth_frame_ram
(
    input  logic                              rx_clk_0_i,
    input  logic                              wr_en_i,
    input  logic [eth_ll_pkg::FIFO_AW-1:0]    wr_addr_i,
    input  logic [eth_client_pkg::DATA_W-1:0] wr_data_i,
    input  logic                              wr_last_i,
    input  logic [eth_ll_pkg::FIFO_AW-1:0]    rd_addr_i,
    output logic [eth_client_pkg::DATA_W-1:0] rd_data_o,
    output logic                              rd_last_o
);

    // End-of-frame flag sits above the byte
    logic [eth_client_pkg::DATA_W:0] mem [eth_ll_pkg::FIFO_DEPTH];
    logic [eth_client_pkg::DATA_W:0] rd_q;

    // One write port, one registered read port
    // A read of the address being written returns the old entry
    always_ff @(posedge rx_clk_0_i)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i] <= {wr_last_i, wr_data_i};
        end
        rd_q <= mem[rd_addr_i];
    end

    assign rd_data_o = rd_q[eth_client_pkg::DATA_W-1:0];
    assign rd_last_o = rd_q[eth_client_pkg::DATA_W];

endmodule

/* common/eth_client_pkg.sv */
package eth_client_pkg;

    // ----------------------------------------
    // MAC client side
    // ----------------------------------------

    // One client byte per clock
    localparam int DATA_W = 8;

    // Stages in the FIFO reset chain
    // Release comes one edge after the last stage clears
    localparam int RESET_DELAY = 6;

endpackage

/* common/eth_ll_pkg.sv */
package eth_ll_pkg;

    // ----------------------------------------
    // Frame FIFO geometry
    // ----------------------------------------

    // Address width of both client FIFOs
    localparam int FIFO_AW = 8;

    // Entries per FIFO, one byte plus end flag each
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // ----------------------------------------
    // Local-link side
    // ----------------------------------------

    // Coarse fill status, committed bytes over 16
    localparam int STATUS_W = 4;

endpackage
